// File: csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Core configuration
////////////////////////////////////////////////////////////////////////////

// Integer register and CSR width
`define XLEN 32

// PMP address registers kept as plain storage
`define PMP_ENTRIES 4

// misa extension bits A..Z
// I (bit 8) and M (bit 12) are reported
`define MISA_EXT 26'h0001100

// Value returned by mimpid
`define MIMPID_VAL 32'h0000_0100

`endif

// File: csrPkg.sv
`default_nettype none

package csrPkg;

  ////////////////////////////////////////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////////////////////////////////////////
  typedef enum logic [11:0] {
    adrMstatus   = 12'h300,
    adrMisa      = 12'h301,
    adrMie       = 12'h304,
    adrMtvec     = 12'h305,
    adrMscratch  = 12'h340,
    adrMepc      = 12'h341,
    adrMcause    = 12'h342,
    adrMtval     = 12'h343,
    adrMip       = 12'h344,
    adrPmpcfg0   = 12'h3A0,
    adrPmpaddr0  = 12'h3B0,
    adrPmpaddr1  = 12'h3B1,
    adrPmpaddr2  = 12'h3B2,
    adrPmpaddr3  = 12'h3B3,
    adrMvendorid = 12'hF11,
    adrMarchid   = 12'hF12,
    adrMimpid    = 12'hF13,
    adrMhartid   = 12'hF14
  } csrAdrT;

  // Same encoding as funct3[1:0] of CSRRW, CSRRS and CSRRC
  typedef enum logic [1:0] {
    opWrite = 2'd1,
    opSet   = 2'd2,
    opClear = 2'd3
  } csrOpT;

  // Exception or interrupt code as held in mcause
  typedef logic [4:0] causeT;

  // Interrupt positions in mip and mie
  localparam int msiBit = 3;
  localparam int mtiBit = 7;
  localparam int meiBit = 11;

  // mstatus fields that exist
  localparam int statusMieBit  = 3;
  localparam int statusMpieBit = 7;
  localparam int statusMppLo   = 11;

endpackage

`default_nettype wire

// File: csrAlu.sv
`include "csr_settings.svh"
`default_nettype none

module csrAlu (
  input  logic              csrValid,
  input  csrPkg::csrOpT     csrOp,
  input  logic [`XLEN-1:0]  csrSrc,
  input  logic [`XLEN-1:0]  oldVal,
  input  logic              stall,
  output logic              csrWrite,
  output logic [`XLEN-1:0]  csrWriteVal
);

  import csrPkg::*;

  logic opWrites;

  // Replace, set bits or clear bits of the current value
  always_comb begin
    case (csrOp)
      opWrite: csrWriteVal = csrSrc;
      opSet:   csrWriteVal = oldVal | csrSrc;
      opClear: csrWriteVal = oldVal & ~csrSrc;
      default: csrWriteVal = oldVal;
    endcase
  end

  // Set or clear with a zero source is only a read
  always_comb begin
    case (csrOp)
      opWrite:        opWrites = 1'b1;
      opSet, opClear: opWrites = |csrSrc;
      default:        opWrites = 1'b0;
    endcase
  end

  assign csrWrite = csrValid && !stall && opWrites;

endmodule

`default_nettype wire

// File: csrM.sv
`include "csr_settings.svh"
`default_nettype none

module csrM (
  input  logic              clk,
  input  logic              rstN,
  input  logic              csrWrite,
  input  logic [11:0]       csrAdr,
  input  logic [`XLEN-1:0]  csrWriteVal,
  input  logic              trapWrite,
  input  logic [`XLEN-1:0]  nextEpc,
  input  logic [`XLEN-1:0]  nextCause,
  input  logic [`XLEN-1:0]  nextTval,
  input  logic [`XLEN-1:0]  mstatusVal,
  input  logic [11:0]       irqLines,
  output logic [`XLEN-1:0]  csrMReadVal,
  output logic [`XLEN-1:0]  mepcVal,
  output logic [`XLEN-1:0]  mtvecVal,
  output logic [11:0]       mieVal,
  output logic              illegal
);

  import csrPkg::*;

  localparam int pmpIdxW = (`PMP_ENTRIES > 1) ? $clog2(`PMP_ENTRIES) : 1;
  localparam logic [11:0] mieMask = 12'((1 << msiBit) | (1 << mtiBit) | (1 << meiBit));
  localparam logic [`XLEN-1:0] misaVal = {2'b01, {(`XLEN-28){1'b0}}, `MISA_EXT};

  logic [`XLEN-1:0]       mscratchReg;
  logic [`XLEN-1:0]       mtvalReg;
  logic [`XLEN-1:0]       pmpCfg0Reg;
  logic [`XLEN-1:0]       pmpAddrReg [`PMP_ENTRIES];
  logic                   mcauseIntr;
  causeT                  mcauseCode;
  logic                   wrMtvec, wrMie, wrMscratch, wrPmpCfg0;
  logic                   wrMepc, wrMcause, wrMtval;
  logic [`PMP_ENTRIES-1:0] wrPmpAddr;
  logic [11:0]            pmpOffset;
  logic                   pmpHit;
  logic                   idReg;
  logic                   unknownAdr;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////
  assign wrMtvec    = csrWrite && (csrAdr == adrMtvec);
  assign wrMie      = csrWrite && (csrAdr == adrMie);
  assign wrMscratch = csrWrite && (csrAdr == adrMscratch);
  assign wrMepc     = csrWrite && (csrAdr == adrMepc);
  assign wrMcause   = csrWrite && (csrAdr == adrMcause);
  assign wrMtval    = csrWrite && (csrAdr == adrMtval);
  assign wrPmpCfg0  = csrWrite && (csrAdr == adrPmpcfg0);

  // pmpaddr registers sit at consecutive addresses
  assign pmpOffset = csrAdr - adrPmpaddr0;
  assign pmpHit    = pmpOffset < 12'(`PMP_ENTRIES);

  for (genvar i = 0; i < `PMP_ENTRIES; i++) begin : genPmpWe
    assign wrPmpAddr[i] = csrWrite && (pmpOffset == 12'(i));
  end

  assign idReg = (csrAdr == adrMvendorid) || (csrAdr == adrMarchid) ||
                 (csrAdr == adrMimpid) || (csrAdr == adrMhartid);

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  // mtvec mode 2 and 3 are reserved so bit 1 stays clear
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtvecVal    <= '0;
      mieVal      <= '0;
      mscratchReg <= '0;
      pmpCfg0Reg  <= '0;
    end else begin
      if (wrMtvec)
        mtvecVal <= {csrWriteVal[`XLEN-1:2], 1'b0, csrWriteVal[0]};
      if (wrMie)
        mieVal <= csrWriteVal[11:0] & mieMask;
      if (wrMscratch)
        mscratchReg <= csrWriteVal;
      if (wrPmpCfg0)
        pmpCfg0Reg <= csrWriteVal;
    end
  end

  // Trap entry takes precedence over a software write
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mepcVal    <= '0;
      mcauseIntr <= 1'b0;
      mcauseCode <= '0;
      mtvalReg   <= '0;
    end else if (trapWrite) begin
      mepcVal    <= {nextEpc[`XLEN-1:2], 2'b00};
      mcauseIntr <= nextCause[`XLEN-1];
      mcauseCode <= nextCause[4:0];
      mtvalReg   <= nextTval;
    end else begin
      if (wrMepc)
        mepcVal <= {csrWriteVal[`XLEN-1:2], 2'b00};
      if (wrMcause) begin
        mcauseIntr <= csrWriteVal[`XLEN-1];
        mcauseCode <= csrWriteVal[4:0];
      end
      if (wrMtval)
        mtvalReg <= csrWriteVal;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `PMP_ENTRIES; i++)
        pmpAddrReg[i] <= '0;
    end else begin
      for (int i = 0; i < `PMP_ENTRIES; i++)
        if (wrPmpAddr[i])
          pmpAddrReg[i] <= csrWriteVal;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    unknownAdr = 1'b0;
    case (csrAdr)
      adrMisa:      csrMReadVal = misaVal;
      adrMvendorid: csrMReadVal = '0;
      adrMarchid:   csrMReadVal = '0;
      adrMimpid:    csrMReadVal = `MIMPID_VAL;
      adrMhartid:   csrMReadVal = '0;
      adrMstatus:   csrMReadVal = mstatusVal;
      adrMtvec:     csrMReadVal = mtvecVal;
      adrMie:       csrMReadVal = {{(`XLEN-12){1'b0}}, mieVal};
      adrMip:       csrMReadVal = {{(`XLEN-12){1'b0}}, irqLines};
      adrMscratch:  csrMReadVal = mscratchReg;
      adrMepc:      csrMReadVal = mepcVal;
      adrMcause:    csrMReadVal = {mcauseIntr, {(`XLEN-6){1'b0}}, mcauseCode};
      adrMtval:     csrMReadVal = mtvalReg;
      adrPmpcfg0:   csrMReadVal = pmpCfg0Reg;
      default: begin
        if (pmpHit) begin
          csrMReadVal = pmpAddrReg[pmpOffset[pmpIdxW-1:0]];
        end else begin
          csrMReadVal = '0;
          unknownAdr  = 1'b1;
        end
      end
    endcase
  end

  // ID registers are read only
  assign illegal = unknownAdr || (csrWrite && idReg);

endmodule

`default_nettype wire

// File: csrStatus.sv
`include "csr_settings.svh"
`default_nettype none

module csrStatus (
  input  logic              clk,
  input  logic              rstN,
  input  logic              csrWrite,
  input  logic [11:0]       csrAdr,
  input  logic [`XLEN-1:0]  csrWriteVal,
  input  logic              trapEnter,
  input  logic              mretDo,
  output logic [`XLEN-1:0]  mstatusVal
);

  import csrPkg::*;

  logic mieFlag;
  logic mpieFlag;
  // Set when MPP holds 3
  logic mppM;
  logic wrStatus;

  assign wrStatus = csrWrite && (csrAdr == adrMstatus);

  // Interrupt-enable stack
  // Only M-mode exists so any MPP update lands on 3
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mieFlag  <= 1'b0;
      mpieFlag <= 1'b0;
      mppM     <= 1'b0;
    end else if (trapEnter) begin
      mpieFlag <= mieFlag;
      mieFlag  <= 1'b0;
      mppM     <= 1'b1;
    end else if (mretDo) begin
      mieFlag  <= mpieFlag;
      mpieFlag <= 1'b1;
      mppM     <= 1'b1;
    end else if (wrStatus) begin
      mieFlag  <= csrWriteVal[statusMieBit];
      mpieFlag <= csrWriteVal[statusMpieBit];
      mppM     <= 1'b1;
    end
  end

  // All other fields read as zero
  always_comb begin
    mstatusVal                   = '0;
    mstatusVal[statusMieBit]     = mieFlag;
    mstatusVal[statusMpieBit]    = mpieFlag;
    mstatusVal[statusMppLo +: 2] = {2{mppM}};
  end

endmodule

`default_nettype wire

// File: trapUnit.sv
`include "csr_settings.svh"
`default_nettype none

module trapUnit (
  input  logic              excValid,
  input  logic              retireValid,
  input  logic              mretValid,
  input  logic              stall,
  input  csrPkg::causeT     excCause,
  input  logic [`XLEN-1:0]  excPc,
  input  logic [`XLEN-1:0]  excTval,
  input  logic [`XLEN-1:0]  nextPc,
  input  logic [`XLEN-1:0]  mstatusVal,
  input  logic [`XLEN-1:0]  mtvecVal,
  input  logic [`XLEN-1:0]  mepcVal,
  input  logic [11:0]       mieVal,
  input  logic [11:0]       irqLines,
  output logic              trapTaken,
  output logic              mretTaken,
  output logic              trapWrite,
  output logic [`XLEN-1:0]  nextEpc,
  output logic [`XLEN-1:0]  nextCause,
  output logic [`XLEN-1:0]  nextTval,
  output logic [`XLEN-1:0]  redirectPc
);

  import csrPkg::*;

  logic [11:0]      pending;
  logic             irqReq;
  logic             trapReq;
  causeT            irqCode;
  logic [`XLEN-1:0] tvecBase;

  ////////////////////////////////////////////////////////////////////////////
  // Selection
  ////////////////////////////////////////////////////////////////////////////
  assign pending = irqLines & mieVal;
  assign irqReq  = retireValid && mstatusVal[statusMieBit] && (|pending);

  // MEI first, then MSI, then MTI
  always_comb begin
    if (pending[meiBit])
      irqCode = causeT'(meiBit);
    else if (pending[msiBit])
      irqCode = causeT'(msiBit);
    else
      irqCode = causeT'(mtiBit);
  end

  // Exception beats interrupt, both beat mret
  assign trapReq   = excValid || irqReq;
  assign trapTaken = trapReq && !stall;
  assign trapWrite = trapTaken;
  assign mretTaken = mretValid && !trapReq && !stall;

  ////////////////////////////////////////////////////////////////////////////
  // Trap state and target
  ////////////////////////////////////////////////////////////////////////////
  assign nextEpc   = excValid ? excPc : nextPc;
  assign nextCause = excValid ? {{(`XLEN-5){1'b0}}, excCause}
                              : {1'b1, {(`XLEN-6){1'b0}}, irqCode};
  assign nextTval  = excValid ? excTval : '0;

  assign tvecBase = {mtvecVal[`XLEN-1:2], 2'b00};

  // Vectored mode only offsets interrupts
  always_comb begin
    if (mretTaken)
      redirectPc = mepcVal;
    else if (mtvecVal[0] && !excValid)
      redirectPc = tvecBase + {{(`XLEN-7){1'b0}}, irqCode, 2'b00};
    else
      redirectPc = tvecBase;
  end

endmodule

`default_nettype wire

// File: csrTop.sv
`include "csr_settings.svh"
`default_nettype none

module csrTop (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stall,
  input  logic              csrValid,
  input  csrPkg::csrOpT     csrOp,
  input  logic [11:0]       csrAdr,
  input  logic [`XLEN-1:0]  csrSrc,
  input  logic              excValid,
  input  csrPkg::causeT     excCause,
  input  logic [`XLEN-1:0]  excPc,
  input  logic [`XLEN-1:0]  excTval,
  input  logic              retireValid,
  input  logic [`XLEN-1:0]  nextPc,
  input  logic              mretValid,
  input  logic [11:0]       irqLines,
  output logic [`XLEN-1:0]  csrReadVal,
  output logic              illegal,
  output logic              trapTaken,
  output logic              mretTaken,
  output logic [`XLEN-1:0]  redirectPc
);

  logic             csrWrite;
  logic [`XLEN-1:0] csrWriteVal;
  logic [`XLEN-1:0] mstatusVal, mepcVal, mtvecVal;
  logic [11:0]      mieVal;
  logic             trapWrite;
  logic [`XLEN-1:0] nextEpc, nextCause, nextTval;
  logic             accessFault;

  csrAlu csrAlu_inst (
    .csrValid(csrValid), .csrOp(csrOp), .csrSrc(csrSrc), .oldVal(csrReadVal),
    .stall(stall), .csrWrite(csrWrite), .csrWriteVal(csrWriteVal)
  );

  // Read value includes mstatus through the mstatusVal input
  csrM csrM_inst (
    .clk(clk), .rstN(rstN), .csrWrite(csrWrite), .csrAdr(csrAdr),
    .csrWriteVal(csrWriteVal), .trapWrite(trapWrite), .nextEpc(nextEpc),
    .nextCause(nextCause), .nextTval(nextTval), .mstatusVal(mstatusVal),
    .irqLines(irqLines), .csrMReadVal(csrReadVal), .mepcVal(mepcVal),
    .mtvecVal(mtvecVal), .mieVal(mieVal), .illegal(accessFault)
  );

  csrStatus csrStatus_inst (
    .clk(clk), .rstN(rstN), .csrWrite(csrWrite), .csrAdr(csrAdr),
    .csrWriteVal(csrWriteVal), .trapEnter(trapTaken), .mretDo(mretTaken),
    .mstatusVal(mstatusVal)
  );

  trapUnit trapUnit_inst (
    .excValid(excValid), .retireValid(retireValid), .mretValid(mretValid),
    .stall(stall), .excCause(excCause), .excPc(excPc), .excTval(excTval),
    .nextPc(nextPc), .mstatusVal(mstatusVal), .mtvecVal(mtvecVal),
    .mepcVal(mepcVal), .mieVal(mieVal), .irqLines(irqLines),
    .trapTaken(trapTaken), .mretTaken(mretTaken), .trapWrite(trapWrite),
    .nextEpc(nextEpc), .nextCause(nextCause), .nextTval(nextTval),
    .redirectPc(redirectPc)
  );

  // Only an actual access can be illegal
  assign illegal = csrValid && accessFault;

endmodule

`default_nettype wire

// File: tbClock.sv
`default_nettype none

module tbClock (
  output logic clk,
  output logic rstN
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int resetCycles = 3;

  initial begin
    clk  = 1'b0;
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
  end

  // 4 ns period
  always #2 clk = ~clk;

endmodule

`default_nettype wire

// File: csrTop_sva.sv
`default_nettype none

module csrTop_sva (
  input logic clk,
  input logic rstN,
  input logic stall,
  input logic excValid,
  input logic trapTaken,
  input logic mretTaken,
  input logic mcauseIntr
);

  timeunit 1ns;
  timeprecision 100ps;

  // Trap entry and mret never share a cycle
  assert property (@(posedge clk) disable iff (!rstN) !(trapTaken && mretTaken))
    else $error("trapTaken and mretTaken high in the same cycle");

  // A stalled cycle takes nothing
  assert property (@(posedge clk) disable iff (!rstN) stall |-> !trapTaken && !mretTaken)
    else $error("trap or mret taken while stall is high");

  // Exception causes land in mcause with the interrupt bit clear
  assert property (@(posedge clk) disable iff (!rstN)
                   trapTaken && excValid |=> !mcauseIntr)
    else $error("mcause interrupt bit set after an exception trap");

endmodule

bind csrTop csrTop_sva csrTop_sva_inst (
  .clk(clk), .rstN(rstN), .stall(stall), .excValid(excValid),
  .trapTaken(trapTaken), .mretTaken(mretTaken), .mcauseIntr(csrM_inst.mcauseIntr)
);

`default_nettype wire

// File: csrTop_tb.sv
`include "csr_settings.svh"
`default_nettype none

module csrTop_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import csrPkg::*;

  localparam int resetTimeout = 20;
  localparam logic [11:0] allAdr [18] = '{adrMvendorid, adrMarchid, adrMimpid, adrMhartid,
    adrMstatus, adrMisa, adrMie, adrMtvec, adrMscratch, adrMepc, adrMcause, adrMtval,
    adrMip, adrPmpcfg0, adrPmpaddr0, adrPmpaddr1, adrPmpaddr2, adrPmpaddr3};
  localparam logic [11:0] writableAdr [9] = '{adrMtvec, adrMie, adrMscratch, adrMepc,
    adrPmpcfg0, adrPmpaddr0, adrPmpaddr1, adrPmpaddr2, adrPmpaddr3};

  logic             clk;
  logic             rstN;
  logic             stall;
  logic             csrValid;
  csrOpT            csrOp;
  logic [11:0]      csrAdr;
  logic [`XLEN-1:0] csrSrc;
  logic             excValid;
  causeT            excCause;
  logic [`XLEN-1:0] excPc;
  logic [`XLEN-1:0] excTval;
  logic             retireValid;
  logic [`XLEN-1:0] nextPc;
  logic             mretValid;
  logic [11:0]      irqLines;
  logic [`XLEN-1:0] csrReadVal;
  logic             illegal;
  logic             trapTaken;
  logic             mretTaken;
  logic [`XLEN-1:0] redirectPc;

  // Expected register contents, indexed by CSR address
  logic [`XLEN-1:0] shadow [4096];
  logic [31:0]      lcgState;
  int               errCount;
  int               checkCount;

  tbClock tbClock_inst (.clk(clk), .rstN(rstN));

  csrTop csrTop_inst (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic isIdAdr(input logic [11:0] adr);
    return adr inside {adrMvendorid, adrMarchid, adrMimpid, adrMhartid};
  endfunction

  function automatic logic isKnownAdr(input logic [11:0] adr);
    return isIdAdr(adr) || adr inside {adrMstatus, adrMisa, adrMie, adrMtvec, adrMscratch,
      adrMepc, adrMcause, adrMtval, adrMip, adrPmpcfg0, adrPmpaddr0, adrPmpaddr1,
      adrPmpaddr2, adrPmpaddr3};
  endfunction

  // misa and mip have no storage
  function automatic logic isWritableAdr(input logic [11:0] adr);
    return isKnownAdr(adr) && !isIdAdr(adr) && adr != adrMisa && adr != adrMip;
  endfunction

  function automatic logic [`XLEN-1:0] warlMask(input logic [11:0] adr,
                                                input logic [`XLEN-1:0] val);
    case (adr)
      adrMtvec:   return val & ~32'h2;
      adrMie:     return val & 32'h888;
      adrMepc:    return val & ~32'h3;
      adrMcause:  return val & 32'h8000_001F;
      adrMstatus: return (val & 32'h88) | 32'h1800;
      default:    return val;
    endcase
  endfunction

  function automatic logic [`XLEN-1:0] refRead(input logic [11:0] adr, input logic [11:0] irq);
    case (adr)
      // MXL of 1 in the top two bits
      adrMisa:   return (`XLEN'(1) << (`XLEN-2)) | `XLEN'(`MISA_EXT);
      adrMimpid: return `MIMPID_VAL;
      adrMip:    return {{(`XLEN-12){1'b0}}, irq};
      default:   return isWritableAdr(adr) ? shadow[adr] : '0;
    endcase
  endfunction

  // Expected redirect, with the expected strobes and interrupt code as outputs
  function automatic logic [`XLEN-1:0] refTrap(input logic exc, input logic retire,
      input logic mret, input logic stallIn, input logic [11:0] irq,
      output logic takeTrap, output logic takeMret, output causeT code);
    logic [11:0]      pending;
    logic             irqReq;
    logic [`XLEN-1:0] base;
    pending = irq & shadow[adrMie][11:0];
    irqReq  = retire && shadow[adrMstatus][3] && (pending != 12'h0);
    if (pending[meiBit])
      code = causeT'(meiBit);
    else if (pending[msiBit])
      code = causeT'(msiBit);
    else
      code = causeT'(mtiBit);
    takeTrap = (exc || irqReq) && !stallIn;
    takeMret = mret && !exc && !irqReq && !stallIn;
    base     = shadow[adrMtvec] & ~32'h3;
    if (takeMret)
      return shadow[adrMepc];
    if (!exc && shadow[adrMtvec][0])
      return base + `XLEN'(code) * 4;
    return base;
  endfunction

  task automatic checkVal(input string name, input logic [`XLEN-1:0] got,
                          input logic [`XLEN-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin : compareBlk
    logic [`XLEN-1:0] oldVal;
    logic [`XLEN-1:0] newVal;
    logic [`XLEN-1:0] expPc;
    logic [`XLEN-1:0] status;
    logic             wrReq;
    logic             expTrap;
    logic             expMret;
    causeT            irqCode;
    if (rstN) begin
      oldVal = refRead(csrAdr, irqLines);
      wrReq  = csrValid && !stall && (csrOp == opWrite || csrSrc != '0);
      case (csrOp)
        opSet:   newVal = oldVal | csrSrc;
        opClear: newVal = oldVal & ~csrSrc;
        default: newVal = csrSrc;
      endcase
      if (csrValid) begin
        checkVal("csrReadVal", csrReadVal, oldVal);
        checkVal("illegal", `XLEN'(illegal),
                 `XLEN'(!isKnownAdr(csrAdr) || (wrReq && isIdAdr(csrAdr))));
      end
      expPc = refTrap(excValid, retireValid, mretValid, stall, irqLines,
                      expTrap, expMret, irqCode);
      if (excValid || retireValid || mretValid) begin
        checkVal("trapTaken", `XLEN'(trapTaken), `XLEN'(expTrap));
        checkVal("mretTaken", `XLEN'(mretTaken), `XLEN'(expMret));
        if (expTrap || expMret)
          checkVal("redirectPc", redirectPc, expPc);
      end
      // Updates seen after the next rising edge, trap and mret over software writes
      status = shadow[adrMstatus];
      if (wrReq && isWritableAdr(csrAdr))
        shadow[csrAdr] = warlMask(csrAdr, newVal);
      if (expMret)
        shadow[adrMstatus] = 32'h1880 | (`XLEN'(status[7]) << 3);
      if (expTrap) begin
        shadow[adrMstatus] = 32'h1800 | (`XLEN'(status[3]) << 7);
        shadow[adrMepc]    = (excValid ? excPc : nextPc) & ~32'h3;
        shadow[adrMcause]  = excValid ? `XLEN'(excCause) : (32'h8000_0000 | `XLEN'(irqCode));
        shadow[adrMtval]   = excValid ? excTval : '0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  task automatic beginCycle();
    @(posedge clk);
    #1;
    stall       = 1'b0;
    csrValid    = 1'b0;
    excValid    = 1'b0;
    retireValid = 1'b0;
    mretValid   = 1'b0;
  endtask

  task automatic csrAccess(input csrOpT op, input logic [11:0] adr,
                           input logic [`XLEN-1:0] src, input logic stallIn);
    beginCycle();
    csrValid = 1'b1;
    csrOp    = op;
    csrAdr   = adr;
    csrSrc   = src;
    stall    = stallIn;
  endtask

  task automatic csrRead(input logic [11:0] adr);
    csrAccess(opSet, adr, '0, 1'b0);
  endtask

  task automatic trapCycle(input logic exc, input logic retire, input logic mret,
                           input logic stallIn, input logic [11:0] irq);
    beginCycle();
    excValid    = exc;
    retireValid = retire;
    mretValid   = mret;
    stall       = stallIn;
    irqLines    = irq;
    excCause    = causeT'(lcgNext() >> 28);
    excPc       = lcgNext();
    excTval     = lcgNext();
    nextPc      = lcgNext();
  endtask

  task automatic waitReset(output logic released);
    int cycles;
    cycles = 0;
    while (rstN !== 1'b1 && cycles < resetTimeout) begin
      @(posedge clk);
      cycles++;
    end
    released = (rstN === 1'b1);
  endtask

  initial begin : mainBlk
    logic             released;
    logic [31:0]      rnd;
    logic [11:0]      adr;
    logic [`XLEN-1:0] src;
    lcgState    = 32'h8e6f1328;
    errCount    = 0;
    checkCount  = 0;
    stall       = 1'b0;
    csrValid    = 1'b0;
    csrOp       = opSet;
    csrAdr      = '0;
    csrSrc      = '0;
    excValid    = 1'b0;
    excCause    = '0;
    excPc       = '0;
    excTval     = '0;
    retireValid = 1'b0;
    nextPc      = '0;
    mretValid   = 1'b0;
    irqLines    = '0;
    for (int i = 0; i < 4096; i++)
      shadow[i] = '0;
    waitReset(released);
    if (!released) begin
      $display("Timeout while waiting for reset to be released");
      errCount++;
    end else begin
      // Reset values
      for (int i = 0; i < 18; i++)
        csrRead(allAdr[i]);
      // Random write, set and clear with read back, some stalled
      for (int i = 0; i < 80; i++) begin
        rnd = lcgNext();
        adr = writableAdr[int'(rnd[31:28]) % 9];
        src = (rnd[25:22] == 4'd0) ? '0 : lcgNext();
        csrAccess(csrOpT'(2'(int'(rnd[27:26]) % 3 + 1)), adr, src, rnd[21:19] == 3'd0);
        csrRead(adr);
      end
      // Illegal accesses
      csrRead(12'h7C0);
      csrRead(12'h3B4);
      csrAccess(opWrite, adrMvendorid, 32'h1, 1'b0);
      csrAccess(opSet, adrMhartid, 32'h4, 1'b0);
      csrAccess(opWrite, adrMimpid, '0, 1'b1);
      csrRead(adrMarchid);
      // Exception entry and mret
      csrAccess(opWrite, adrMtvec, 32'h0000_0100, 1'b0);
      csrAccess(opWrite, adrMstatus, 32'h8, 1'b0);
      trapCycle(1'b1, 1'b0, 1'b0, 1'b1, '0);
      trapCycle(1'b1, 1'b0, 1'b0, 1'b0, '0);
      csrRead(adrMepc);
      csrRead(adrMcause);
      csrRead(adrMtval);
      csrRead(adrMstatus);
      trapCycle(1'b0, 1'b0, 1'b1, 1'b0, '0);
      csrRead(adrMstatus);
      // Interrupt gating by mie and MIE
      csrAccess(opWrite, adrMie, '0, 1'b0);
      trapCycle(1'b0, 1'b1, 1'b0, 1'b0, 12'h888);
      csrAccess(opWrite, adrMie, 32'h888, 1'b0);
      csrAccess(opClear, adrMstatus, 32'h8, 1'b0);
      trapCycle(1'b0, 1'b1, 1'b0, 1'b0, 12'h888);
      csrAccess(opSet, adrMstatus, 32'h8, 1'b0);
      trapCycle(1'b0, 1'b1, 1'b0, 1'b1, 12'h888);
      // Priority MEI, MSI, MTI
      trapCycle(1'b0, 1'b1, 1'b0, 1'b0, 12'h888);
      csrRead(adrMcause);
      trapCycle(1'b0, 1'b0, 1'b1, 1'b0, '0);
      trapCycle(1'b0, 1'b1, 1'b0, 1'b0, 12'h088);
      trapCycle(1'b0, 1'b0, 1'b1, 1'b0, '0);
      trapCycle(1'b0, 1'b1, 1'b0, 1'b0, 12'h080);
      trapCycle(1'b0, 1'b0, 1'b1, 1'b0, '0);
      // Vectored mtvec, then an exception beside an interrupt
      csrAccess(opWrite, adrMtvec, 32'h0000_0201, 1'b0);
      trapCycle(1'b0, 1'b1, 1'b0, 1'b0, 12'h080);
      trapCycle(1'b0, 1'b0, 1'b1, 1'b0, '0);
      trapCycle(1'b1, 1'b1, 1'b0, 1'b0, 12'h888);
      csrRead(adrMcause);
      trapCycle(1'b0, 1'b0, 1'b1, 1'b0, '0);
      // Random traps, sometimes with a CSR write in the same cycle
      for (int i = 0; i < 60; i++) begin
        rnd = lcgNext();
        trapCycle(rnd[31:29] == 3'd0, rnd[28], rnd[27:26] == 2'd0, rnd[25:23] == 3'd0,
                  12'(lcgNext() >> 20));
        if (rnd[22]) begin
          csrValid = 1'b1;
          csrOp    = opWrite;
          csrAdr   = rnd[21] ? adrMepc : adrMstatus;
          csrSrc   = lcgNext();
        end
        if (rnd[20:19] == 2'd0)
          csrAccess(opSet, adrMstatus, 32'h8, 1'b0);
      end
      beginCycle();
    end
    $display("Checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: csrTop.f
+incdir+.
csrPkg.sv
csrAlu.sv
csrM.sv
csrStatus.sv
trapUnit.sv
csrTop.sv
tbClock.sv
csrTop_sva.sv
csrTop_tb.sv

// File: Makefile
TB_TOP = csrTop_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f csrTop.f --top-module csrTop

sim:
	verilator --binary --timing --timescale 1ns/100ps -f csrTop.f --top-module $(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
